/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_processorci
FLIST      := flist.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := test passed
SOURCES    := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/cmd_rx.sv */
`timescale 1ns/1ps
`include "pci_consts.svh"

module cmd_rx (
    input  logic            sys_clk,
    input  logic            reset_i,
    input  logic            rx_valid_i,
    input  pci_pkg::byte_t  rx_byte_i,
    output logic            rx_credit_o,
    output logic            cmd_valid_o,
    output pci_pkg::cmd_t   cmd_o,
    input  logic            cmd_ready_i
);

    localparam int PTR_BITS = $clog2(`PCI_RX_DEPTH);
    localparam int CNT_BITS = $clog2(`PCI_FRAME_BYTES);

    pci_pkg::byte_t      fifo_q [`PCI_RX_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   fill;
    logic                pop;

    logic [CNT_BITS-1:0] byte_cnt;
    pci_pkg::byte_t      opcode_q;
    logic [63:0]         payload_q;   // {data, addr}, filled from the top down

    // Hold off the assembler while a finished frame waits
    assign pop         = (fill != '0) && !cmd_valid_o;
    assign rx_credit_o = pop;         // One credit back per byte drained

    // Host only sends with a credit in hand, so no overflow check here
    always_ff @(posedge sys_clk) begin
        if (rx_valid_i) begin
            fifo_q[wr_ptr] <= rx_byte_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (rx_valid_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop)        rd_ptr <= rd_ptr + 1'b1;
            case ({rx_valid_i, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Frame assembly, address and data arrive LSB first
    always_ff @(posedge sys_clk) begin
        if (pop) begin
            if (byte_cnt == '0) begin
                opcode_q <= fifo_q[rd_ptr];
            end else begin
                payload_q <= {fifo_q[rd_ptr], payload_q[63:8]};
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            byte_cnt    <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            if (cmd_valid_o && cmd_ready_i) begin
                cmd_valid_o <= 1'b0;
            end
            if (pop) begin
                if (byte_cnt == CNT_BITS'(`PCI_FRAME_BYTES - 1)) begin
                    byte_cnt    <= '0;
                    cmd_valid_o <= 1'b1;   // Ninth byte lands this cycle
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    assign cmd_o.opcode = opcode_q;
    assign cmd_o.addr   = payload_q[31:0];
    assign cmd_o.data   = payload_q[63:32];

endmodule

/* design/pci_consts.svh */
`ifndef PCI_CONSTS_SVH
`define PCI_CONSTS_SVH

// Program memory geometry
`define PCI_MEM_WORDS   256
`define PCI_ADDR_BITS   8

// Host frame is opcode + 4 address bytes + 4 data bytes
`define PCI_FRAME_BYTES 9

// Link flow control
`define PCI_RX_DEPTH    4     // Also the host's starting credits
`define PCI_TX_CREDITS  2

// Opcodes and status
`define PCI_OP_WRITE    8'h01
`define PCI_OP_READ     8'h02
`define PCI_OP_RUN      8'h03
`define PCI_RSP_ERR     8'hEE

`endif

/* design/pci_controller.sv */
`timescale 1ns/1ps
`include "pci_consts.svh"

module pci_controller (
    input  logic                 sys_clk,
    input  logic                 reset_i,
    input  logic                 cmd_valid_i,
    input  pci_pkg::cmd_t        cmd_i,
    output logic                 cmd_ready_o,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output pci_pkg::mem_addr_t   mem_addr_o,
    output pci_pkg::word_t       mem_wdata_o,
    input  pci_pkg::word_t       mem_rdata_i,
    output logic                 rst_core_o,
    output logic                 rsp_valid_o,
    output pci_pkg::rsp_t        rsp_o,
    input  logic                 rsp_ready_i
);

    pci_pkg::ctrl_state_t  state;
    pci_pkg::cmd_t         cmd_q;
    pci_pkg::cycle_count_t run_left;
    pci_pkg::rsp_t         rsp_q;
    logic                  mem_wait;   // Read issued, data arrives next cycle
    logic                  accept;

    assign accept      = cmd_valid_i && cmd_ready_o;
    assign cmd_ready_o = (state == pci_pkg::IDLE);
    assign rsp_valid_o = (state == pci_pkg::REPLY);
    assign rsp_o       = rsp_q;

    // Host addresses are word indices into the program memory
    assign mem_req_o   = (state == pci_pkg::MEM) && !mem_wait;
    assign mem_we_o    = (cmd_q.opcode == `PCI_OP_WRITE);
    assign mem_addr_o  = cmd_q.addr[`PCI_ADDR_BITS-1:0];
    assign mem_wdata_o = cmd_q.data;

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            cmd_q    <= cmd_i;
            run_left <= cmd_i.data;
        end else if (state == pci_pkg::RUN) begin
            run_left <= run_left - 1'b1;
        end
    end

    // Response payload
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            rsp_q.data     <= '0;
            rsp_q.has_data <= 1'b0;
            case (cmd_i.opcode)
                `PCI_OP_WRITE, `PCI_OP_READ, `PCI_OP_RUN: rsp_q.status <= cmd_i.opcode;
                default:                                  rsp_q.status <= `PCI_RSP_ERR;
            endcase
        end else if (state == pci_pkg::MEM && mem_wait) begin
            rsp_q.data     <= mem_rdata_i;
            rsp_q.has_data <= 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            state      <= pci_pkg::IDLE;
            rst_core_o <= 1'b1;
            mem_wait   <= 1'b0;
        end else begin
            case (state)
                pci_pkg::IDLE: begin
                    if (accept) begin
                        case (cmd_i.opcode)
                            `PCI_OP_WRITE, `PCI_OP_READ: state <= pci_pkg::MEM;
                            `PCI_OP_RUN: begin
                                if (cmd_i.data == '0) begin
                                    state <= pci_pkg::REPLY;   // Nothing to run
                                end else begin
                                    state      <= pci_pkg::RUN;
                                    rst_core_o <= 1'b0;
                                end
                            end
                            default: state <= pci_pkg::REPLY;
                        endcase
                    end
                end
                pci_pkg::MEM: begin
                    if (mem_wait) begin
                        mem_wait <= 1'b0;
                        state    <= pci_pkg::REPLY;
                    end else if (mem_we_o) begin
                        state <= pci_pkg::REPLY;   // Write done in one cycle
                    end else begin
                        mem_wait <= 1'b1;
                    end
                end
                pci_pkg::RUN: begin
                    // Last released cycle, back into reset
                    if (run_left == 32'd1) begin
                        rst_core_o <= 1'b1;
                        state      <= pci_pkg::REPLY;
                    end
                end
                pci_pkg::REPLY: begin
                    if (rsp_ready_i) state <= pci_pkg::IDLE;
                end
                default: state <= pci_pkg::IDLE;
            endcase
        end
    end

endmodule

/* design/pci_pkg.sv */
`include "pci_consts.svh"

package pci_pkg;

    typedef logic [31:0]                 word_t;
    typedef logic [7:0]                  byte_t;
    typedef logic [`PCI_ADDR_BITS-1:0]   mem_addr_t;    // Word index
    typedef logic [31:0]                 cycle_count_t;

    // One decoded host frame
    typedef struct packed {
        byte_t opcode;
        word_t addr;
        word_t data;      // Write data or run length
    } cmd_t;

    // Reply to the host, status first on the wire
    typedef struct packed {
        byte_t status;
        word_t data;
        logic  has_data;  // Only READ carries a word
    } rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        MEM,
        RUN,
        REPLY
    } ctrl_state_t;

endpackage

/* design/processorci_top.sv */
`timescale 1ns/1ps

module processorci_top (
    input  logic            sys_clk,
    input  logic            reset_i,

    // Host byte link
    input  logic            rx_valid_i,
    input  pci_pkg::byte_t  rx_byte_i,
    output logic            rx_credit_o,
    output logic            tx_valid_o,
    output pci_pkg::byte_t  tx_byte_o,
    input  logic            tx_credit_i,

    // Core Wishbone bus
    input  logic            core_cyc_i,
    input  logic            core_stb_i,
    input  logic            core_we_i,
    input  pci_pkg::word_t  core_addr_i,
    input  pci_pkg::word_t  core_data_i,
    output pci_pkg::word_t  core_data_o,
    output logic            core_ack_o,
    output logic            rst_core_o
);

    logic               cmd_valid;
    logic               cmd_ready;
    pci_pkg::cmd_t      cmd;
    logic               rsp_valid;
    logic               rsp_ready;
    pci_pkg::rsp_t      rsp;

    // Controller side of the memory
    logic               mem_req;
    logic               mem_we;
    pci_pkg::mem_addr_t mem_addr;
    pci_pkg::word_t     mem_wdata;
    pci_pkg::word_t     mem_rdata;

    cmd_rx u_cmd_rx (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .rx_valid_i  (rx_valid_i),
        .rx_byte_i   (rx_byte_i),
        .rx_credit_o (rx_credit_o),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd),
        .cmd_ready_i (cmd_ready)
    );

    pci_controller u_ctrl (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .cmd_ready_o (cmd_ready),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .rst_core_o  (rst_core_o),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .rsp_ready_i (rsp_ready)
    );

    wb_memory u_mem (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .core_cyc_i  (core_cyc_i),
        .core_stb_i  (core_stb_i),
        .core_we_i   (core_we_i),
        .core_addr_i (core_addr_i),
        .core_data_i (core_data_i),
        .core_data_o (core_data_o),
        .core_ack_o  (core_ack_o),
        .mem_req_i   (mem_req),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata)
    );

    rsp_tx u_rsp_tx (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp),
        .rsp_ready_o (rsp_ready),
        .tx_valid_o  (tx_valid_o),
        .tx_byte_o   (tx_byte_o),
        .tx_credit_i (tx_credit_i)
    );

endmodule

/* design/rsp_tx.sv */
`timescale 1ns/1ps
`include "pci_consts.svh"

module rsp_tx (
    input  logic            sys_clk,
    input  logic            reset_i,
    input  logic            rsp_valid_i,
    input  pci_pkg::rsp_t   rsp_i,
    output logic            rsp_ready_o,
    output logic            tx_valid_o,
    output pci_pkg::byte_t  tx_byte_o,
    input  logic            tx_credit_i
);

    localparam int CRED_BITS = $clog2(`PCI_TX_CREDITS + 1);

    logic [CRED_BITS-1:0] credits;
    logic                 busy;
    logic [2:0]           bytes_left;  // 1 or 5 at start
    logic [39:0]          shift_q;     // Status in the low byte, then data LSB first
    logic                 send;

    assign rsp_ready_o = !busy;
    assign send        = busy && (credits != '0);
    assign tx_valid_o  = send;
    assign tx_byte_o   = shift_q[7:0];

    always_ff @(posedge sys_clk) begin
        if (rsp_valid_i && rsp_ready_o) begin
            shift_q <= {rsp_i.data, rsp_i.status};
        end else if (send) begin
            shift_q <= {8'h00, shift_q[39:8]};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            busy       <= 1'b0;
            bytes_left <= '0;
        end else if (rsp_valid_i && rsp_ready_o) begin
            busy       <= 1'b1;
            bytes_left <= rsp_i.has_data ? 3'd5 : 3'd1;
        end else if (send) begin
            bytes_left <= bytes_left - 1'b1;
            if (bytes_left == 3'd1) busy <= 1'b0;
        end
    end

    // Spend on send, refill on credit pulse
    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            credits <= CRED_BITS'(`PCI_TX_CREDITS);
        end else begin
            case ({send, tx_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // Both or neither
            endcase
        end
    end

endmodule

/* design/wb_memory.sv */
`timescale 1ns/1ps
`include "pci_consts.svh"

module wb_memory (
    input  logic                sys_clk,
    input  logic                reset_i,
    input  logic                core_cyc_i,
    input  logic                core_stb_i,
    input  logic                core_we_i,
    input  pci_pkg::word_t      core_addr_i,
    input  pci_pkg::word_t      core_data_i,
    output pci_pkg::word_t      core_data_o,
    output logic                core_ack_o,
    input  logic                mem_req_i,
    input  logic                mem_we_i,
    input  pci_pkg::mem_addr_t  mem_addr_i,
    input  pci_pkg::word_t      mem_wdata_i,
    output pci_pkg::word_t      mem_rdata_o
);

    pci_pkg::word_t     mem_q [`PCI_MEM_WORDS];
    pci_pkg::mem_addr_t core_idx;
    logic               core_take;

    // Byte address from the core, word index in bits 9:2
    assign core_idx  = core_addr_i[`PCI_ADDR_BITS+1:2];

    // New transfer only when the previous cycle was not an ack
    assign core_take = core_cyc_i && core_stb_i && !core_ack_o;

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            core_ack_o <= 1'b0;
        end else begin
            core_ack_o <= core_take;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (core_take) begin
            if (core_we_i) mem_q[core_idx] <= core_data_i;
            core_data_o <= mem_q[core_idx];   // Valid alongside the ack
        end
        // Controller port; only active while the core sits in reset
        if (mem_req_i) begin
            if (mem_we_i) mem_q[mem_addr_i] <= mem_wdata_i;
            mem_rdata_o <= mem_q[mem_addr_i];
        end
    end

endmodule

/* flist.f */
+incdir+design
design/pci_pkg.sv
design/cmd_rx.sv
design/pci_controller.sv
design/wb_memory.sv
design/rsp_tx.sv
design/processorci_top.sv
sim/processorci_props.sv
sim/tb_processorci.sv

/* sim/processorci_props.sv */
`timescale 1ns/1ps
`include "pci_consts.svh"

module processorci_props (
    input logic sys_clk,
    input logic reset_i,
    input logic rx_valid_i,
    input logic rx_credit_i,
    input logic tx_valid_i,
    input logic tx_credit_i,
    input logic core_ack_i
);

    int host_credits;   // Host view of the receive buffer
    int tx_credits;     // Transmitter credit mirror

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            host_credits <= `PCI_RX_DEPTH;
            tx_credits   <= `PCI_TX_CREDITS;
        end else begin
            host_credits <= host_credits - int'(rx_valid_i) + int'(rx_credit_i);
            tx_credits   <= tx_credits - int'(tx_valid_i) + int'(tx_credit_i);
        end
    end

    // A credit returned this cycle may be spent this cycle
    host_credit_ok: assert property (@(posedge sys_clk) disable iff (reset_i)
        host_credits + int'(rx_credit_i) - int'(rx_valid_i) >= 0)
        else $error("host has more bytes outstanding than the receive buffer holds");

    // Credits come back only for bytes the buffer has taken
    host_credit_max: assert property (@(posedge sys_clk) disable iff (reset_i)
        host_credits + int'(rx_credit_i) - int'(rx_valid_i) <= `PCI_RX_DEPTH)
        else $error("receive buffer returned more credits than bytes it received");

    tx_credit_ok: assert property (@(posedge sys_clk) disable iff (reset_i)
        tx_valid_i |-> tx_credits > 0)
        else $error("tx_valid_o high with no credit left");

    single_ack: assert property (@(posedge sys_clk) disable iff (reset_i)
        core_ack_i |=> !core_ack_i)
        else $error("core_ack_o high two cycles in a row");

endmodule

bind processorci_top processorci_props u_props (
    .sys_clk     (sys_clk),
    .reset_i     (reset_i),
    .rx_valid_i  (rx_valid_i),
    .rx_credit_i (rx_credit_o),
    .tx_valid_i  (tx_valid_o),
    .tx_credit_i (tx_credit_i),
    .core_ack_i  (core_ack_o)
);

/* sim/tb_processorci.sv */
`timescale 1ns/1ps
`include "pci_consts.svh"

module tb_processorci;

    localparam int SCRIPT_LEN  = 16;       // Core model does 8 writes, then 8 reads
    localparam int CORE_BASE   = 128;      // Core works in the upper half of memory
    // About 45 frames at roughly 15 cycles, a 300 cycle credit stall and two runs
    // come to under 1500 cycles, so the limit leaves a wide margin
    localparam int CYCLE_LIMIT = 20000;

    logic           sys_clk;
    logic           reset_i;
    logic           rx_valid_i;
    pci_pkg::byte_t rx_byte_i;
    logic           rx_credit_o;
    logic           tx_valid_o;
    pci_pkg::byte_t tx_byte_o;
    logic           tx_credit_i;
    logic           core_cyc_i;
    logic           core_stb_i;
    logic           core_we_i;
    pci_pkg::word_t core_addr_i;
    pci_pkg::word_t core_data_i;
    pci_pkg::word_t core_data_o;
    logic           core_ack_o;
    logic           rst_core_o;

    int                    seed = 28;
    string                 cur_test;
    int                    cycle_cnt;
    pci_pkg::word_t        shadow [`PCI_MEM_WORDS];
    logic                  shadow_ok [`PCI_MEM_WORDS];   // Core region words written so far
    pci_pkg::byte_t        host_bytes [$];               // Bytes waiting for an rx credit
    pci_pkg::cmd_t         exp_cmds [$];                 // Commands still owed a response
    pci_pkg::cycle_count_t run_q [$];
    int                    host_credits;
    int                    dut_tx_credits;               // Credits the DUT holds
    int                    credits_owed;
    int                    credit_delay;
    logic                  withhold;
    pci_pkg::cycle_count_t byte_count;
    pci_pkg::cycle_count_t low_cycles;
    pci_pkg::cmd_t         mon_cmd;
    pci_pkg::rsp_t         cur_exp;
    pci_pkg::word_t        got_word;
    int                    rsp_left;
    int                    core_step;
    logic                  script_we  [SCRIPT_LEN];
    pci_pkg::mem_addr_t    script_idx [SCRIPT_LEN];
    pci_pkg::word_t        script_dat [SCRIPT_LEN];

    processorci_top i_dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_status(input pci_pkg::byte_t exp, input pci_pkg::byte_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s status: expected %h, actual %h",
                                    cur_test, exp, act));
        end
    endtask

    task automatic check_word(input pci_pkg::word_t exp, input pci_pkg::word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s word: expected %h, actual %h",
                                    cur_test, exp, act));
        end
    endtask

    task automatic check_count(input pci_pkg::cycle_count_t exp,
                               input pci_pkg::cycle_count_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s count: expected %0d, actual %0d",
                                    cur_test, exp, act));
        end
    endtask

    // Expected reply from the shadow memory
    function automatic pci_pkg::rsp_t ref_response(input pci_pkg::cmd_t c);
        pci_pkg::rsp_t r;
        r.status   = c.opcode;
        r.data     = '0;
        r.has_data = 1'b0;
        case (c.opcode)
            `PCI_OP_WRITE, `PCI_OP_RUN: r.has_data = 1'b0;
            `PCI_OP_READ: begin
                r.has_data = 1'b1;
                r.data     = shadow[c.addr[`PCI_ADDR_BITS-1:0]];
            end
            default: r.status = `PCI_RSP_ERR;
        endcase
        return r;
    endfunction

    function automatic pci_pkg::cmd_t make_cmd(input pci_pkg::byte_t op,
                                               input pci_pkg::word_t addr,
                                               input pci_pkg::word_t data);
        pci_pkg::cmd_t c;
        c.opcode = op;
        c.addr   = addr;
        c.data   = data;
        return c;
    endfunction

    // Opcode, then address and data LSB first
    task automatic send_frame(input pci_pkg::cmd_t c);
        host_bytes.push_back(c.opcode);
        for (int i = 0; i < 4; i++) host_bytes.push_back(c.addr[8*i +: 8]);
        for (int i = 0; i < 4; i++) host_bytes.push_back(c.data[8*i +: 8]);
        exp_cmds.push_back(c);
        if (c.opcode == `PCI_OP_RUN && c.data != '0) run_q.push_back(c.data);
    endtask

    task automatic wait_idle();
        do begin
            @(posedge sys_clk);
        end while (host_bytes.size() != 0 || exp_cmds.size() != 0 || rsp_left != 0);
    endtask

    task automatic read_core_words();
        for (int i = CORE_BASE; i < CORE_BASE + 8; i++) begin
            if (shadow_ok[i]) send_frame(make_cmd(`PCI_OP_READ, i, '0));
        end
        wait_idle();
    endtask

    // Host sender, spends one rx credit per byte
    always @(negedge sys_clk) begin
        if (!reset_i) begin
            if (rx_credit_o) host_credits++;
            if (host_bytes.size() != 0 && host_credits > 0) begin
                rx_valid_i = 1'b1;
                rx_byte_i  = host_bytes.pop_front();
                host_credits--;
            end else begin
                rx_valid_i = 1'b0;
            end
        end
    end

    // Response monitor and tx credit return
    always @(negedge sys_clk) begin
        if (!reset_i) begin
            if (tx_valid_o) begin
                if (dut_tx_credits == 0) stop_on_error("response byte sent without a tx credit");
                dut_tx_credits--;
                credits_owed++;
                byte_count++;
                if (rsp_left == 0) begin
                    if (exp_cmds.size() == 0) stop_on_error("response byte with no command pending");
                    mon_cmd = exp_cmds.pop_front();
                    cur_exp = ref_response(mon_cmd);
                    if (mon_cmd.opcode == `PCI_OP_WRITE) begin
                        shadow[mon_cmd.addr[`PCI_ADDR_BITS-1:0]] = mon_cmd.data;
                    end
                    check_status(cur_exp.status, tx_byte_o);
                    rsp_left = cur_exp.has_data ? 4 : 0;
                end else begin
                    got_word = {tx_byte_o, got_word[31:8]};
                    rsp_left--;
                    if (rsp_left == 0) check_word(cur_exp.data, got_word);
                end
            end
            if (credits_owed != 0 && !withhold && credit_delay == 0) begin
                tx_credit_i = 1'b1;
                credits_owed--;
                dut_tx_credits++;
                credit_delay = $random(seed) & 3;
            end else begin
                tx_credit_i = 1'b0;
                if (credit_delay != 0) credit_delay--;
            end
        end
    end

    // Core model, one Wishbone transfer per ack, plus run length check
    always @(negedge sys_clk) begin
        if (!reset_i) begin
            if (!rst_core_o) begin
                low_cycles++;
            end else if (low_cycles != 0) begin
                if (run_q.size() == 0) stop_on_error("core left reset without a RUN command");
                check_count(run_q.pop_front(), low_cycles);
                low_cycles = 0;
            end
            if (core_ack_o) begin
                if (script_we[core_step]) begin
                    shadow[script_idx[core_step]]    = script_dat[core_step];
                    shadow_ok[script_idx[core_step]] = 1'b1;
                end else begin
                    check_word(shadow[script_idx[core_step]], core_data_o);
                end
                core_step++;
            end
            if (!rst_core_o && core_step < SCRIPT_LEN) begin
                core_cyc_i  = 1'b1;
                core_stb_i  = 1'b1;
                core_we_i   = script_we[core_step];
                core_addr_i = {22'd0, script_idx[core_step], 2'b00};  // Byte address
                core_data_i = script_dat[core_step];
            end else begin
                core_cyc_i = 1'b0;
                core_stb_i = 1'b0;
            end
        end
    end

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) stop_on_error("timeout, responses stopped arriving");
    end

    initial begin
        pci_pkg::mem_addr_t    addrs [$];
        pci_pkg::mem_addr_t    a;
        pci_pkg::cycle_count_t snap;
        reset_i     = 1'b1;
        rx_valid_i  = 1'b0;
        rx_byte_i   = '0;
        tx_credit_i = 1'b0;
        core_cyc_i  = 1'b0;
        core_stb_i  = 1'b0;
        core_we_i   = 1'b0;
        core_addr_i = '0;
        core_data_i = '0;
        withhold       = 1'b0;
        host_credits   = `PCI_RX_DEPTH;
        dut_tx_credits = `PCI_TX_CREDITS;
        credits_owed   = 0;
        credit_delay   = 0;
        byte_count     = '0;
        low_cycles     = '0;
        rsp_left       = 0;
        core_step      = 0;
        cycle_cnt      = 0;
        for (int i = 0; i < `PCI_MEM_WORDS; i++) shadow_ok[i] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            script_we[i]      = 1'b1;
            script_idx[i]     = CORE_BASE + i;
            script_dat[i]     = $random(seed);
            script_we[8+i]    = 1'b0;
            script_idx[8+i]   = CORE_BASE + 7 - i;   // Read back in reverse
            script_dat[8+i]   = '0;
        end
        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        reset_i = 1'b0;

        cur_test = "write then read";
        for (int i = 0; i < 8; i++) begin
            a = {1'b0, 7'($random(seed))};   // Host keeps to the lower half
            addrs.push_back(a);
            send_frame(make_cmd(`PCI_OP_WRITE, a, $random(seed)));
        end
        foreach (addrs[i]) send_frame(make_cmd(`PCI_OP_READ, addrs[i], '0));
        wait_idle();

        cur_test = "unknown opcode";
        send_frame(make_cmd(8'h5A, addrs[0], $random(seed)));
        send_frame(make_cmd(`PCI_OP_READ, addrs[0], '0));
        wait_idle();

        cur_test = "core run";
        send_frame(make_cmd(`PCI_OP_RUN, '0, 32'd9));   // Stops partway through the script
        wait_idle();
        read_core_words();
        send_frame(make_cmd(`PCI_OP_RUN, '0, 32'd0));
        send_frame(make_cmd(`PCI_OP_RUN, '0, 32'd40));
        wait_idle();
        read_core_words();

        cur_test = "withheld credits";
        withhold = 1'b1;
        snap = byte_count + dut_tx_credits;   // Only the credits in hand can be spent
        send_frame(make_cmd(`PCI_OP_WRITE, addrs[1], $random(seed)));
        send_frame(make_cmd(`PCI_OP_READ, addrs[1], '0));
        send_frame(make_cmd(8'hC7, addrs[2], '0));
        repeat (300) @(posedge sys_clk);
        check_count(snap, byte_count);
        withhold = 1'b0;
        wait_idle();

        cur_test = "back to back";
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0) begin
                send_frame(make_cmd(`PCI_OP_WRITE, addrs[i], $random(seed)));
            end else begin
                send_frame(make_cmd(`PCI_OP_READ, addrs[i-1], '0));
            end
        end
        send_frame(make_cmd(`PCI_OP_READ, addrs[7], '0));
        wait_idle();
        repeat (20) @(posedge sys_clk);

        if (core_step == SCRIPT_LEN && run_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("core script or a run length check did not complete");
            $display("test failed");
            $fatal(1, "run ended with checks outstanding");
        end
    end

endmodule
